/* rtl/coreTypes.sv */
package coreTypes;

	localparam int xlen = 32;

	// opcode groups
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opReg    = 7'b0110011;

	localparam logic [31:0] ebreakInst = 32'h0010_0073;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB
	} aluOp_t;

	// same width code as the data bus, 2 is never used
	typedef enum logic [1:0] {
		lenByte = 2'd0,
		lenHalf = 2'd1,
		lenWord = 2'd3
	} accessLen_t;

	typedef enum logic [1:0] {
		wbAlu,
		wbLoad,
		wbPcPlus4,
		wbPcTarget // auipc
	} wbSel_t;

	typedef enum logic [1:0] {
		pcSelPlus4,
		pcSelTarget,
		pcSelJalr
	} pcSel_t;

	typedef struct packed {
		aluOp_t     aluOp;
		logic       aluSrcImm;
		logic       regWrite;
		logic       memWrite;
		accessLen_t accessLen;
		logic       loadSigned;
		wbSel_t     wbSel;
		logic       isBranch;
		logic       isJal;
		logic       isJalr;
	} ctrl_t;

	typedef struct packed {
		logic [xlen-1:0] address;
		logic [xlen-1:0] storeData;
		accessLen_t      accessLen;
		logic            memWrite;
	} dataAccess_t;

endpackage

/* rtl/decoder.sv */
`timescale 1ns/1ps

module decoder import coreTypes::*; (
	input  logic [31:0] inst,
	input  logic        reset,
	output ctrl_t       ctrl,
	output logic        invalid,
	output logic        halt
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       altOp; // funct7 bit 5, picks sub and sra
	logic       valid;
	ctrl_t      dec;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign altOp  = inst[30];

	function automatic accessLen_t lenOf(input logic [1:0] f);
		case (f)
			2'b00:   lenOf = lenByte;
			2'b01:   lenOf = lenHalf;
			default: lenOf = lenWord;
		endcase
	endfunction

	// shared by the register and immediate groups
	function automatic aluOp_t arithOp(input logic [2:0] f, input logic alt);
		case (f)
			3'b000:  arithOp = alt ? aluSub : aluAdd;
			3'b001:  arithOp = aluSll;
			3'b010:  arithOp = aluSlt;
			3'b011:  arithOp = aluSltu;
			3'b100:  arithOp = aluXor;
			3'b101:  arithOp = alt ? aluSra : aluSrl;
			3'b110:  arithOp = aluOr;
			default: arithOp = aluAnd;
		endcase
	endfunction

	always_comb begin
		dec   = '0;
		valid = 1'b0;
		case (opcode)
			opLui: begin
				valid         = 1'b1;
				dec.aluOp     = aluAdd; // srcA is zero here
				dec.aluSrcImm = 1'b1;
				dec.regWrite  = 1'b1;
				dec.wbSel     = wbAlu;
			end
			opAuipc: begin
				valid         = 1'b1;
				dec.aluOp     = aluPassB;
				dec.aluSrcImm = 1'b1;
				dec.regWrite  = 1'b1;
				dec.wbSel     = wbPcTarget;
			end
			opJal: begin
				valid         = 1'b1;
				dec.aluOp     = aluPassB;
				dec.aluSrcImm = 1'b1;
				dec.regWrite  = 1'b1;
				dec.wbSel     = wbPcPlus4;
				dec.isJal     = 1'b1;
			end
			opJalr: begin
				valid         = funct3 == 3'b000;
				dec.aluOp     = aluAdd;
				dec.aluSrcImm = 1'b1;
				dec.regWrite  = 1'b1;
				dec.wbSel     = wbPcPlus4;
				dec.isJalr    = valid;
			end
			opBranch: begin
				valid        = funct3 == 3'b000; // beq only
				dec.aluOp    = aluSub;
				dec.isBranch = valid;
			end
			opLoad: begin
				valid          = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
				dec.aluOp      = aluAdd;
				dec.aluSrcImm  = 1'b1;
				dec.regWrite   = 1'b1;
				dec.accessLen  = lenOf(funct3[1:0]);
				dec.loadSigned = ~funct3[2];
				dec.wbSel      = wbLoad;
			end
			opStore: begin
				valid         = funct3 inside {3'b000, 3'b001, 3'b010};
				dec.aluOp     = aluAdd;
				dec.aluSrcImm = 1'b1;
				dec.memWrite  = 1'b1;
				dec.accessLen = lenOf(funct3[1:0]);
			end
			opImm: begin
				valid         = !(funct3 inside {3'b001, 3'b101}); // no immediate shifts
				dec.aluOp     = arithOp(funct3, 1'b0);
				dec.aluSrcImm = 1'b1;
				dec.regWrite  = 1'b1;
				dec.wbSel     = wbAlu;
			end
			opReg: begin
				valid        = 1'b1;
				dec.aluOp    = arithOp(funct3, altOp);
				dec.regWrite = 1'b1;
				dec.wbSel    = wbAlu;
			end
			default: ;
		endcase
		if (inst == ebreakInst)
			valid = 1'b1;
	end

	always_comb begin
		ctrl = dec;
		if (reset || !valid) begin
			ctrl.regWrite = 1'b0;
			ctrl.memWrite = 1'b0;
		end
	end

	assign invalid = ~valid;
	assign halt    = inst == ebreakInst;

endmodule

/* rtl/immGen.sv */
`timescale 1ns/1ps

module immGen import coreTypes::*; (
	input  logic [31:0]     inst,
	output logic [xlen-1:0] imm
);

	logic [6:0] opcode;

	assign opcode = inst[6:0];

	always_comb begin
		case (opcode)
			opImm, opLoad, opJalr:
				imm = {{20{inst[31]}}, inst[31:20]};
			opStore:
				imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			opBranch:
				imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			opLui, opAuipc:
				imm = {inst[31:12], 12'b0};
			opJal:
				imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			default:
				imm = '0;
		endcase
	end

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps

module regFile import coreTypes::*; (
	input  logic            clk,
	input  logic            reset,
	input  logic            regWrite,
	input  logic [4:0]      rs1,
	input  logic [4:0]      rs2,
	input  logic [4:0]      rd,
	input  logic [xlen-1:0] writeData,
	output logic [xlen-1:0] rs1Data,
	output logic [xlen-1:0] rs2Data
);

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (regWrite && rd != 5'd0) begin
			regs[rd] <= writeData;
		end
	end

	// x0 reads as zero
	assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu import coreTypes::*; (
	input  aluOp_t          aluOp,
	input  logic [xlen-1:0] srcA,
	input  logic [xlen-1:0] srcB,
	output logic [xlen-1:0] result,
	output logic            zero
);

	logic [4:0] shamt;

	assign shamt = srcB[4:0];

	always_comb begin
		case (aluOp)
			aluAdd:   result = srcA + srcB;
			aluSub:   result = srcA - srcB;
			aluSll:   result = srcA << shamt;
			aluSlt:   result = {31'b0, $signed(srcA) < $signed(srcB)};
			aluSltu:  result = {31'b0, srcA < srcB};
			aluXor:   result = srcA ^ srcB;
			aluSrl:   result = srcA >> shamt;
			aluSra:   result = $unsigned($signed(srcA) >>> shamt);
			aluOr:    result = srcA | srcB;
			aluAnd:   result = srcA & srcB;
			aluPassB: result = srcB;
			default:  result = '0;
		endcase
	end

	assign zero = result == '0; // beq after sub

endmodule

/* rtl/pcUnit.sv */
`timescale 1ns/1ps

module pcUnit import coreTypes::*; #(
	parameter logic [xlen-1:0] resetVector = '0
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            halt,
	input  ctrl_t           ctrl,
	input  logic            zero,
	input  logic [xlen-1:0] imm,
	input  logic [xlen-1:0] jalrTarget,
	output logic [xlen-1:0] pc,
	output logic [xlen-1:0] pcPlus4,
	output logic [xlen-1:0] pcTarget
);

	pcSel_t          pcSel;
	logic [xlen-1:0] nextPc;

	assign pcPlus4  = pc + 32'd4;
	assign pcTarget = pc + imm; // branch, jal and auipc

	always_comb begin
		if (ctrl.isJalr)
			pcSel = pcSelJalr;
		else if (ctrl.isJal || (ctrl.isBranch && zero))
			pcSel = pcSelTarget;
		else
			pcSel = pcSelPlus4;
	end

	always_comb begin
		case (pcSel)
			pcSelTarget: nextPc = pcTarget;
			pcSelJalr:   nextPc = {jalrTarget[xlen-1:1], 1'b0};
			default:     nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= resetVector;
		else if (!halt) // ebreak parks here
			pc <= nextPc;
	end

endmodule

/* rtl/writeback.sv */
`timescale 1ns/1ps

module writeback import coreTypes::*; (
	input  ctrl_t           ctrl,
	input  logic [xlen-1:0] readData,
	input  logic [xlen-1:0] aluResult,
	input  logic [xlen-1:0] pcPlus4,
	input  logic [xlen-1:0] pcTarget,
	output logic [xlen-1:0] writeData
);

	logic [xlen-1:0] loadData;
	logic            byteSign;
	logic            halfSign;

	// load data arrives in the low bits
	assign byteSign = ctrl.loadSigned & readData[7];
	assign halfSign = ctrl.loadSigned & readData[15];

	always_comb begin
		case (ctrl.accessLen)
			lenByte: loadData = {{24{byteSign}}, readData[7:0]};
			lenHalf: loadData = {{16{halfSign}}, readData[15:0]};
			default: loadData = readData;
		endcase
	end

	always_comb begin
		case (ctrl.wbSel)
			wbLoad:     writeData = loadData;
			wbPcPlus4:  writeData = pcPlus4;
			wbPcTarget: writeData = pcTarget;
			default:    writeData = aluResult;
		endcase
	end

endmodule

/* rtl/singleCycleCore.sv */
`timescale 1ns/1ps

module singleCycleCore import coreTypes::*; #(
	parameter logic [xlen-1:0] resetVector = '0
) (
	input  logic            clk,
	input  logic            reset,
	input  logic [31:0]     inst,
	input  logic [xlen-1:0] readData,
	output logic [xlen-1:0] pc,
	output dataAccess_t     dataAccess,
	output logic            invalid,
	output logic            halt
);

	ctrl_t           ctrl;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] rs1Data;
	logic [xlen-1:0] rs2Data;
	logic [xlen-1:0] srcA;
	logic [xlen-1:0] srcB;
	logic [xlen-1:0] aluResult;
	logic            zero;
	logic [xlen-1:0] pcPlus4;
	logic [xlen-1:0] pcTarget;
	logic [xlen-1:0] writeData;

	decoder decoder_i (
		.inst    (inst),
		.reset   (reset),
		.ctrl    (ctrl),
		.invalid (invalid),
		.halt    (halt)
	);

	immGen immGen_i (
		.inst (inst),
		.imm  (imm)
	);

	regFile regFile_i (
		.clk       (clk),
		.reset     (reset),
		.regWrite  (ctrl.regWrite),
		.rs1       (inst[19:15]),
		.rs2       (inst[24:20]),
		.rd        (inst[11:7]),
		.writeData (writeData),
		.rs1Data   (rs1Data),
		.rs2Data   (rs2Data)
	);

	// lui bits 19:15 are immediate, not a register
	assign srcA = (inst[6:0] == opLui) ? '0 : rs1Data;
	assign srcB = ctrl.aluSrcImm ? imm : rs2Data;

	alu alu_i (
		.aluOp  (ctrl.aluOp),
		.srcA   (srcA),
		.srcB   (srcB),
		.result (aluResult),
		.zero   (zero)
	);

	pcUnit #(
		.resetVector (resetVector)
	) pcUnit_i (
		.clk        (clk),
		.reset      (reset),
		.halt       (halt),
		.ctrl       (ctrl),
		.zero       (zero),
		.imm        (imm),
		.jalrTarget (aluResult),
		.pc         (pc),
		.pcPlus4    (pcPlus4),
		.pcTarget   (pcTarget)
	);

	writeback writeback_i (
		.ctrl      (ctrl),
		.readData  (readData),
		.aluResult (aluResult),
		.pcPlus4   (pcPlus4),
		.pcTarget  (pcTarget),
		.writeData (writeData)
	);

	assign dataAccess = '{
		address:   aluResult,
		storeData: rs2Data, // unshifted, memory picks the lanes
		accessLen: ctrl.accessLen,
		memWrite:  ctrl.memWrite
	};

endmodule

/* sim/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#5;
		reset = 1'b0;
	end

endmodule

/* sim/coreTb.sv */
`timescale 1ns/1ps

module coreTb import coreTypes::*; ();

	localparam logic [31:0] resetVector = 32'h0000_1000;
	localparam logic [31:0] nop = 32'h0000_0013;
	localparam int maxCycles = 400; // tests take about 200 cycles

	logic        clk;
	logic        reset;
	logic [31:0] inst;
	logic [31:0] readData;
	logic [31:0] pc;
	dataAccess_t dataAccess;
	logic        invalid;
	logic        halt;

	logic [31:0] expRegs [32];
	logic [31:0] expPc;
	logic [31:0] seed;
	int          errors;
	int          checks;
	int          cycles;

	clockGen clockGen_i (
		.clk   (clk),
		.reset (reset)
	);

	singleCycleCore #(
		.resetVector (resetVector)
	) singleCycleCore_i (
		.clk        (clk),
		.reset      (reset),
		.inst       (inst),
		.readData   (readData),
		.pc         (pc),
		.dataAccess (dataAccess),
		.invalid    (invalid),
		.halt       (halt)
	);

	always @(posedge clk) begin
		cycles++;
		if (cycles >= maxCycles) begin
			$display("timeout after %0d cycles, %0d errors in %0d checks", cycles, errors, checks);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] nextRandom();
		seed = xorshift(seed);
		return seed;
	endfunction

	function automatic logic [31:0] rType(input logic alt, input logic [4:0] rs2, rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opReg};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2, rs1,
		input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2, rs1);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	// RV32I arithmetic by funct3 with alt from funct7 bit 5
	function automatic logic [31:0] refOp(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return {31'b0, $signed(a) < $signed(b)};
			3'b011:  return {31'b0, a < b};
			3'b100:  return a ^ b;
			3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] loadExt(input logic [2:0] f3, input logic [31:0] d);
		case (f3)
			3'b000:  return {{24{d[7]}}, d[7:0]};
			3'b001:  return {{16{d[15]}}, d[15:0]};
			3'b100:  return {24'b0, d[7:0]};
			3'b101:  return {16'b0, d[15:0]};
			default: return d;
		endcase
	endfunction

	function automatic logic [1:0] lenCode(input logic [2:0] f3);
		return f3[1] ? 2'd3 : {1'b0, f3[0]};
	endfunction

	function automatic logic accepted(input logic [31:0] w);
		case (w[6:0])
			opLui, opAuipc, opJal, opReg: return 1'b1;
			opJalr, opBranch:             return w[14:12] == 3'b000;
			opLoad:  return w[14:12] inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
			opStore: return w[14:12] inside {3'b000, 3'b001, 3'b010};
			opImm:   return !(w[14:12] inside {3'b001, 3'b101});
			default: return w == ebreakInst;
		endcase
	endfunction

	task automatic checkVal(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("error %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("error %s: got %h, expected %h", name, got, expected);
		end
	endtask

	// one instruction per cycle with outputs sampled once settled
	task automatic issue(input logic [31:0] word, input logic [31:0] rdata);
		@(posedge clk);
		#5;
		inst     = word;
		readData = rdata;
		#20;
		checkVal("pc", pc, expPc);
		checkBit("halt", halt, word == ebreakInst);
		checkBit("invalid", invalid, !accepted(word));
	endtask

	task automatic execAlu(input logic [31:0] word, input logic [4:0] rd,
		input logic [31:0] expected);
		issue(word, nextRandom());
		checkVal("dataAccess.address", dataAccess.address, expected);
		checkBit("dataAccess.memWrite", dataAccess.memWrite, 1'b0);
		if (rd != 5'd0)
			expRegs[rd] = expected;
		expPc += 32'd4;
	endtask

	task automatic setReg(input logic [4:0] rd, input logic [31:0] value);
		logic [19:0] upper;
		upper = value[31:12] + {19'b0, value[11]}; // addi sign-extends the low part
		execAlu(uType(upper, rd, opLui), rd, {upper, 12'b0});
		execAlu(iType(value[11:0], rd, 3'b000, rd, opImm), rd, value);
	endtask

	task automatic execStore(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [11:0] imm);
		issue(sType(imm, rs2, rs1, f3), nextRandom());
		checkBit("dataAccess.memWrite", dataAccess.memWrite, 1'b1);
		checkVal("dataAccess.accessLen", 32'(dataAccess.accessLen), 32'(lenCode(f3)));
		checkVal("dataAccess.address", dataAccess.address, expRegs[rs1] + sext12(imm));
		checkVal("dataAccess.storeData", dataAccess.storeData, expRegs[rs2]);
		expPc += 32'd4;
	endtask

	task automatic execLoad(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [11:0] imm, input logic [31:0] rdata);
		issue(iType(imm, rs1, f3, rd, opLoad), rdata);
		checkVal("dataAccess.address", dataAccess.address, expRegs[rs1] + sext12(imm));
		checkBit("dataAccess.memWrite", dataAccess.memWrite, 1'b0);
		expRegs[rd] = loadExt(f3, rdata);
		expPc += 32'd4;
		execStore(rd, 5'd0, 3'b010, 12'h000); // shows the extended value
	endtask

	task automatic testReset();
		expPc = resetVector;
		for (int i = 0; i < 3; i++) begin
			issue(i < 2 ? sType(12'h010, 5'd1, 5'd0, 3'b010) : nop, 32'd0);
			checkBit("dataAccess.memWrite", dataAccess.memWrite, 1'b0);
		end
		expPc += 32'd4;
	endtask

	task automatic testArith();
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm;
		logic [19:0] upper;
		for (int round = 0; round < 4; round++) begin
			a = nextRandom();
			b = nextRandom();
			setReg(5'd1, a);
			setReg(5'd2, b);
			for (int f = 0; f < 8; f++) begin
				execAlu(rType(1'b0, 5'd2, 5'd1, 3'(f), 5'd3), 5'd3, refOp(3'(f), 1'b0, a, b));
				if (f == 0 || f == 5)
					execAlu(rType(1'b1, 5'd2, 5'd1, 3'(f), 5'd3), 5'd3,
						refOp(3'(f), 1'b1, a, b));
				if (f != 1 && f != 5) begin
					imm = 12'(nextRandom());
					execAlu(iType(imm, 5'd1, 3'(f), 5'd4, opImm), 5'd4,
						refOp(3'(f), 1'b0, a, sext12(imm)));
				end
			end
			upper = 20'(nextRandom());
			issue(uType(upper, 5'd5, opAuipc), nextRandom());
			checkBit("dataAccess.memWrite", dataAccess.memWrite, 1'b0);
			expRegs[5] = expPc + {upper, 12'b0};
			expPc += 32'd4;
			execStore(5'd5, 5'd0, 3'b010, 12'(nextRandom()));
		end
	endtask

	task automatic testStores();
		for (int round = 0; round < 2; round++) begin
			setReg(5'd6, nextRandom());
			setReg(5'd7, nextRandom());
			execStore(5'd6, 5'd7, 3'b000, 12'(nextRandom()));
			execStore(5'd6, 5'd7, 3'b001, 12'(nextRandom()));
			execStore(5'd6, 5'd7, 3'b010, 12'(nextRandom()));
		end
	endtask

	task automatic testLoads();
		setReg(5'd7, nextRandom());
		for (int round = 0; round < 2; round++)
			for (int f = 0; f < 8; f++)
				if (f inside {0, 1, 2, 4, 5})
					execLoad(5'd8, 5'd7, 3'(f), 12'(nextRandom()), nextRandom());
	endtask

	task automatic testControl();
		logic [31:0] v;
		logic [31:0] base;
		v = nextRandom();
		setReg(5'd9, v);
		setReg(5'd10, v);
		issue(bType(13'h0040, 5'd10, 5'd9), nextRandom());
		checkBit("dataAccess.memWrite", dataAccess.memWrite, 1'b0);
		expPc += 32'h40; // equal so taken
		setReg(5'd10, v + 32'd1);
		issue(bType(13'h0040, 5'd10, 5'd9), nextRandom());
		checkBit("dataAccess.memWrite", dataAccess.memWrite, 1'b0);
		expPc += 32'd4;
		issue(jType(21'h1fff80, 5'd11), nextRandom()); // back by 128
		expRegs[11] = expPc + 32'd4;
		expPc -= 32'h80;
		execStore(5'd11, 5'd0, 3'b010, 12'h020);
		base = 32'h0000_2000 | (nextRandom() & 32'h0000_0ff0);
		setReg(5'd12, base);
		issue(iType(12'h005, 5'd12, 3'b000, 5'd13, opJalr), nextRandom());
		expRegs[13] = expPc + 32'd4;
		expPc = (base + 32'd5) & ~32'd1; // odd target loses bit 0
		execStore(5'd13, 5'd0, 3'b010, 12'h024);
	endtask

	task automatic testRandom();
		logic [31:0] w;
		for (int n = 0; n < 50; n++) begin
			w = nextRandom();
			w[1:0] = 2'b11;
			if (w[6:0] == opJal)
				w[3] = 1'b0; // now jalr
			if (w[6:0] == opJalr || w[6:0] == opBranch)
				w[12] = 1'b1; // nonzero funct3 never jumps
			if (w == ebreakInst)
				w[20] = 1'b0;
			if (accepted(w))
				w[11:7] = 5'd0; // valid words may only write x0
			issue(w, nextRandom());
			if (!accepted(w))
				checkBit("dataAccess.memWrite", dataAccess.memWrite, 1'b0);
			expPc += 32'd4;
		end
		// invalid words with a real rd must not have written it
		for (int r = 1; r < 14; r += 4)
			execStore(5'(r), 5'd0, 3'b010, 12'h000);
	endtask

	task automatic testHalt();
		issue(ebreakInst, 32'd0);
		issue(ebreakInst, 32'd0);
		issue(nop, 32'd0); // pc still parked
		expPc += 32'd4;
		issue(nop, 32'd0);
	endtask

	initial begin
		inst     = nop;
		readData = '0;
		seed     = 32'd55;
		errors   = 0;
		checks   = 0;
		cycles   = 0;
		for (int r = 0; r < 32; r++)
			expRegs[r] = '0;
		testReset();
		testArith();
		testStores();
		testLoads();
		testControl();
		testRandom();
		testHalt();
		$display("%0d errors in %0d checks over %0d cycles", errors, checks, cycles);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* vlog.f */
rtl/coreTypes.sv
rtl/decoder.sv
rtl/immGen.sv
rtl/regFile.sv
rtl/alu.sv
rtl/pcUnit.sv
rtl/writeback.sv
rtl/singleCycleCore.sv
sim/clockGen.sv
sim/coreTb.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --assert --timing --top-module coreTb -f vlog.f -o coreTb \
	|| { echo "compile failed"; exit 1; }
./obj_dir/coreTb > sim.log 2>&1
cat sim.log
grep -q "All checks passed" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
